// File: common/isa_pkg.sv
package isa_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_IDX_W = 3;
   localparam int OPC_W     = 5;
   localparam int NUM_REGS  = 8;

   // Bit positions of the instruction fields
   localparam int OPC_LSB = 11;
   localparam int RS_LSB  = 8;
   localparam int RT_LSB  = 5;
   localparam int RD_LSB  = 2;

   localparam int IMM5_W = 5;
   localparam int IMM8_W = 8;

   // R-type function codes in bits 1:0
   localparam logic [1:0] FN_ADD = 2'b00;
   localparam logic [1:0] FN_SUB = 2'b01;
   localparam logic [1:0] FN_XOR = 2'b10;
   localparam logic [1:0] FN_AND = 2'b11;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [OPC_W-1:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      ADDI  = 5'b01000,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      SLBI  = 5'b10010,
      LBI   = 5'b11000,
      RTYPE = 5'b11011
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_LBI,
      ALU_SLBI
   } alu_op_t;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;
   import isa_pkg::*;

   // Operand source picked by the forwarding unit
   typedef logic [1:0] fwd_sel_t;

   localparam fwd_sel_t FWD_RF     = 2'd0;
   localparam fwd_sel_t FWD_EX_MEM = 2'd1;
   localparam fwd_sel_t FWD_MEM_WB = 2'd2;

   typedef struct packed {
      logic  valid;
      word_t instruction;
      word_t pc_inc;
   } if_id_t;

   typedef struct packed {
      logic     valid;
      logic     halt;
      alu_op_t  alu_op;
      reg_idx_t rs;
      reg_idx_t rt;
      logic     uses_rt;
      word_t    rs_data;
      word_t    rt_data;
      word_t    imm;
      logic     imm_sel;
      logic     branch;
      logic     branch_on_zero;
      word_t    pc_inc;
      logic     wr_en;
      reg_idx_t wr_reg;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      logic     halt;
      logic     wr_en;
      reg_idx_t wr_reg;
      word_t    result;
   } ex_mem_t;

   // Memory stage does nothing, so write-back carries the same entry
   typedef ex_mem_t mem_wb_t;

endpackage

// File: decode/reg_file.sv
`timescale 1ns/100ps

module reg_file
   import isa_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  reg_idx_t rd_idx_1,
   input  reg_idx_t rd_idx_2,
   output word_t    rd_data_1,
   output word_t    rd_data_2,
   input  logic     wr_en,
   input  reg_idx_t wr_reg,
   input  word_t    wr_data
);

   word_t regs [NUM_REGS];

   // Same-cycle write shows through to the read port
   function automatic word_t read_port(input reg_idx_t idx);
      if (wr_en && wr_reg == idx) begin
         return wr_data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rd_data_1 = read_port(rd_idx_1);
      rd_data_2 = read_port(rd_idx_2);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_reg] <= wr_data;
      end
   end

endmodule

// File: decode/decode.sv
`timescale 1ns/100ps

module decode
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  if_id_t   if_id,
   input  logic     redirect,
   input  logic     wr_en,
   input  reg_idx_t wr_reg,
   input  word_t    wr_data,
   output id_ex_t   id_ex
);

   word_t    instr;
   opcode_t  opcode;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd;
   word_t    rs_data;
   word_t    rt_data;
   word_t    sext5;
   word_t    sext8;
   word_t    zext8;
   logic     issue;
   logic     halt_pending;
   id_ex_t   dec;

   assign instr  = if_id.instruction;
   assign opcode = opcode_t'(instr[OPC_LSB +: OPC_W]);
   assign rs     = instr[RS_LSB +: REG_IDX_W];
   assign rt     = instr[RT_LSB +: REG_IDX_W];
   assign rd     = instr[RD_LSB +: REG_IDX_W];
   assign sext5  = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
   assign sext8  = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
   assign zext8  = {{(WORD_W-IMM8_W){1'b0}}, instr[IMM8_W-1:0]};

   reg_file u_reg_file (
      .clk       (clk),
      .rst       (rst),
      .rd_idx_1  (rs),
      .rd_idx_2  (rt),
      .rd_data_1 (rs_data),
      .rd_data_2 (rt_data),
      .wr_en     (wr_en),
      .wr_reg    (wr_reg),
      .wr_data   (wr_data)
   );

   // Bubble when flushed by a branch or behind HALT
   assign issue = if_id.valid & ~redirect & ~halt_pending;

   always_comb begin
      dec         = '0;
      dec.valid   = issue;
      dec.rs      = rs;
      dec.rt      = rt;
      dec.rs_data = rs_data;
      dec.rt_data = rt_data;
      dec.pc_inc  = if_id.pc_inc;
      case (opcode)
         HALT: dec.halt = 1'b1;
         RTYPE: begin
            dec.uses_rt = 1'b1;
            dec.wr_en   = 1'b1;
            dec.wr_reg  = rd;
            case (instr[1:0])
               FN_ADD:  dec.alu_op = ALU_ADD;
               FN_SUB:  dec.alu_op = ALU_SUB;
               FN_XOR:  dec.alu_op = ALU_XOR;
               default: dec.alu_op = ALU_AND;
            endcase
         end
         ADDI: begin
            dec.imm     = sext5;
            dec.imm_sel = 1'b1;
            dec.wr_en   = 1'b1;
            dec.wr_reg  = rt;
         end
         LBI: begin
            dec.alu_op  = ALU_LBI;
            dec.imm     = sext8;
            dec.imm_sel = 1'b1;
            dec.wr_en   = 1'b1;
            dec.wr_reg  = rs;
         end
         SLBI: begin
            dec.alu_op  = ALU_SLBI;
            dec.imm     = zext8;
            dec.imm_sel = 1'b1;
            dec.wr_en   = 1'b1;
            dec.wr_reg  = rs;
         end
         // No register write for branches
         BEQZ, BNEZ: begin
            dec.branch         = 1'b1;
            dec.branch_on_zero = (opcode == BEQZ);
            dec.imm            = sext8;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         halt_pending <= 1'b0;
      end else if (issue && opcode == HALT) begin
         halt_pending <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.valid <= 1'b0;
      end else begin
         id_ex <= dec;
      end
   end

endmodule

// File: execute/forward.sv
`timescale 1ns/100ps

module forward
   import isa_pkg::*, pipe_pkg::*;
(
   input  id_ex_t   id_ex,
   input  ex_mem_t  ex_mem,
   input  mem_wb_t  mem_wb,
   output fwd_sel_t fwd_rs_sel,
   output fwd_sel_t fwd_rt_sel
);

   logic ex_mem_writes;
   logic mem_wb_writes;

   // Youngest matching producer wins
   function automatic fwd_sel_t pick_source(input logic needed, input reg_idx_t src,
                                            input logic ex_wr, input reg_idx_t ex_reg,
                                            input logic wb_wr, input reg_idx_t wb_reg);
      if (!needed) begin
         return FWD_RF;
      end
      if (ex_wr && ex_reg == src) begin
         return FWD_EX_MEM;
      end
      if (wb_wr && wb_reg == src) begin
         return FWD_MEM_WB;
      end
      return FWD_RF;
   endfunction

   assign ex_mem_writes = ex_mem.valid & ex_mem.wr_en;
   assign mem_wb_writes = mem_wb.valid & mem_wb.wr_en;

   assign fwd_rs_sel = pick_source(id_ex.valid, id_ex.rs,
                                   ex_mem_writes, ex_mem.wr_reg,
                                   mem_wb_writes, mem_wb.wr_reg);

   // Rt only matters for register-to-register ops
   assign fwd_rt_sel = pick_source(id_ex.valid & id_ex.uses_rt, id_ex.rt,
                                   ex_mem_writes, ex_mem.wr_reg,
                                   mem_wb_writes, mem_wb.wr_reg);

endmodule

// File: execute/execute.sv
`timescale 1ns/100ps

module execute
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  id_ex_t   id_ex,
   input  mem_wb_t  mem_wb,
   input  fwd_sel_t fwd_rs_sel,
   input  fwd_sel_t fwd_rt_sel,
   output logic     redirect,
   output word_t    redirect_pc,
   output ex_mem_t  ex_mem
);

   word_t op_a;
   word_t rt_val;
   word_t op_b;
   word_t result;
   logic  is_zero;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val,
                                     input word_t ex_val, input word_t wb_val);
      case (sel)
         FWD_EX_MEM: return ex_val;
         FWD_MEM_WB: return wb_val;
         default:    return rf_val;
      endcase
   endfunction

   assign op_a   = fwd_mux(fwd_rs_sel, id_ex.rs_data, ex_mem.result, mem_wb.result);
   assign rt_val = fwd_mux(fwd_rt_sel, id_ex.rt_data, ex_mem.result, mem_wb.result);
   assign op_b   = id_ex.imm_sel ? id_ex.imm : rt_val;

   // SUB computes Rs minus Rt
   always_comb begin
      case (id_ex.alu_op)
         ALU_ADD:  result = op_a + op_b;
         ALU_SUB:  result = op_a - op_b;
         ALU_AND:  result = op_a & op_b;
         ALU_XOR:  result = op_a ^ op_b;
         ALU_LBI:  result = op_b;
         ALU_SLBI: result = (op_a << 8) | op_b;
         default:  result = op_a + op_b;
      endcase
   end

   // Branch tests the forwarded Rs value
   assign is_zero     = (op_a == '0);
   assign redirect    = id_ex.valid & id_ex.branch & (is_zero == id_ex.branch_on_zero);
   assign redirect_pc = id_ex.pc_inc + id_ex.imm;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_mem.valid <= 1'b0;
      end else begin
         ex_mem.valid  <= id_ex.valid;
         ex_mem.halt   <= id_ex.halt;
         ex_mem.wr_en  <= id_ex.wr_en;
         ex_mem.wr_reg <= id_ex.wr_reg;
         ex_mem.result <= result;
      end
   end

endmodule

// File: hw/fetch.sv
`timescale 1ns/100ps

module fetch
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  word_t  instr,
   input  logic   redirect,
   input  word_t  redirect_pc,
   output word_t  pc,
   output if_id_t if_id
);

   word_t pc_inc;

   assign pc_inc = pc + 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= redirect_pc;
      end else begin
         pc <= pc_inc;
      end
   end

   // Word fetched in the same cycle as a taken branch is dropped
   always_ff @(posedge clk) begin
      if (rst) begin
         if_id.valid <= 1'b0;
      end else begin
         if_id.valid       <= ~redirect;
         if_id.instruction <= instr;
         if_id.pc_inc      <= pc_inc;
      end
   end

endmodule

// File: hw/writeback.sv
`timescale 1ns/100ps

module writeback
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  ex_mem_t  ex_mem,
   output mem_wb_t  mem_wb,
   output logic     wb_en,
   output reg_idx_t wb_reg,
   output word_t    wb_data,
   output logic     halted
);

   logic halt_seen;
   logic halt_retire;

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_wb.valid <= 1'b0;
      end else begin
         mem_wb <= ex_mem;
      end
   end

   assign halt_retire = mem_wb.valid & mem_wb.halt;

   // Stays set until the next reset
   always_ff @(posedge clk) begin
      if (rst) begin
         halt_seen <= 1'b0;
      end else if (halt_retire) begin
         halt_seen <= 1'b1;
      end
   end

   assign wb_en   = mem_wb.valid & mem_wb.wr_en;
   assign wb_reg  = mem_wb.wr_reg;
   assign wb_data = mem_wb.result;
   assign halted  = halt_seen | halt_retire;

endmodule

// File: hw/proc.sv
`timescale 1ns/100ps

module proc
   import isa_pkg::*, pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   output word_t    pc,
   input  word_t    instr,
   output logic     wb_en,
   output reg_idx_t wb_reg,
   output word_t    wb_data,
   output logic     halted
);

   if_id_t   if_id;
   id_ex_t   id_ex;
   ex_mem_t  ex_mem;
   mem_wb_t  mem_wb;
   logic     redirect;
   word_t    redirect_pc;
   fwd_sel_t fwd_rs_sel;
   fwd_sel_t fwd_rt_sel;

   fetch u_fetch (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .pc          (pc),
      .if_id       (if_id)
   );

   decode u_decode (
      .clk      (clk),
      .rst      (rst),
      .if_id    (if_id),
      .redirect (redirect),
      .wr_en    (wb_en),
      .wr_reg   (wb_reg),
      .wr_data  (wb_data),
      .id_ex    (id_ex)
   );

   execute u_execute (
      .clk         (clk),
      .rst         (rst),
      .id_ex       (id_ex),
      .mem_wb      (mem_wb),
      .fwd_rs_sel  (fwd_rs_sel),
      .fwd_rt_sel  (fwd_rt_sel),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .ex_mem      (ex_mem)
   );

   forward u_forward (
      .id_ex      (id_ex),
      .ex_mem     (ex_mem),
      .mem_wb     (mem_wb),
      .fwd_rs_sel (fwd_rs_sel),
      .fwd_rt_sel (fwd_rt_sel)
   );

   writeback u_writeback (
      .clk     (clk),
      .rst     (rst),
      .ex_mem  (ex_mem),
      .mem_wb  (mem_wb),
      .wb_en   (wb_en),
      .wb_reg  (wb_reg),
      .wb_data (wb_data),
      .halted  (halted)
   );

endmodule

// File: test/proc_model.svh
`ifndef PROC_MODEL_SVH
`define PROC_MODEL_SVH

// Instruction memory read with HALT past the end of the program
function automatic word_t fetch_word(input word_t addr);
   if (addr < PROG_LEN) begin
      return prog[int'(addr)];
   end
   return HALT_WORD;
endfunction

function automatic word_t random_instruction();
   logic [31:0] pick;
   logic [31:0] bits;
   logic [5:0]  sel;
   opcode_t     op;
   pick = lcg_next();
   bits = lcg_next();
   sel  = pick[31:26];
   if (sel < 6'd20) op = RTYPE;
   else if (sel < 6'd30) op = ADDI;
   else if (sel < 6'd38) op = LBI;
   else if (sel < 6'd46) op = SLBI;
   else if (sel < 6'd53) op = BEQZ;
   else if (sel < 6'd60) op = BNEZ;
   else if (sel < 6'd63) op = NOP;
   else op = HALT;
   // Forward branch offsets of 0 to 3
   if (op == BEQZ || op == BNEZ) begin
      return {op, bits[26:24], 6'b0, bits[17:16]};
   end
   return {op, bits[26:16]};
endfunction

function automatic void build_program();
   for (int i = 0; i < PROG_LEN; i++) begin
      prog[i] = random_instruction();
   end
endfunction

// Architectural run of prog one instruction at a time
function automatic void run_model();
   word_t    regs [NUM_REGS];
   word_t    ins;
   word_t    a;
   word_t    b;
   word_t    imm5;
   word_t    imm8;
   word_t    res;
   word_t    mpc;
   reg_idx_t wreg;
   logic     wr;
   logic     stop;
   for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
   end
   exp_reg.delete();
   exp_data.delete();
   mpc  = '0;
   stop = 1'b0;
   while (!stop) begin
      ins  = fetch_word(mpc);
      a    = regs[ins[10:8]];
      b    = regs[ins[7:5]];
      imm5 = $signed(ins[4:0]);
      imm8 = $signed(ins[7:0]);
      wr   = 1'b0;
      wreg = ins[4:2];
      res  = '0;
      mpc  = mpc + 16'd1;
      case (opcode_t'(ins[15:11]))
         HALT: stop = 1'b1;
         RTYPE: begin
            wr = 1'b1;
            case (ins[1:0])
               2'b00:   res = a + b;
               2'b01:   res = a - b;
               2'b10:   res = a ^ b;
               default: res = a & b;
            endcase
         end
         ADDI: begin
            wr   = 1'b1;
            wreg = ins[7:5];
            res  = a + imm5;
         end
         LBI: begin
            wr   = 1'b1;
            wreg = ins[10:8];
            res  = imm8;
         end
         SLBI: begin
            wr   = 1'b1;
            wreg = ins[10:8];
            res  = {a[7:0], ins[7:0]};
         end
         BEQZ: if (a == 16'd0) mpc = mpc + imm8;
         BNEZ: if (a != 16'd0) mpc = mpc + imm8;
         default: ;
      endcase
      if (wr) begin
         regs[wreg] = res;
         exp_reg.push_back(wreg);
         exp_data.push_back(res);
      end
   end
endfunction

`endif

// File: test/proc_tb.sv
`timescale 1ns/100ps

module proc_tb
   import isa_pkg::*;
();

   localparam int NUM_PROGS      = 40;
   localparam int PROG_LEN       = 30;
   localparam int RST_CYCLES     = 4;
   localparam int TAIL_CYCLES    = 3;
   localparam int SEQ_PC_CYCLES  = 3;
   localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN + 10);

   localparam word_t HALT_WORD = {HALT, 11'b0};

   logic     clk;
   logic     rst;
   word_t    pc;
   word_t    instr;
   logic     wb_en;
   reg_idx_t wb_reg;
   word_t    wb_data;
   logic     halted;

   word_t       prog [PROG_LEN];
   reg_idx_t    exp_reg [$];
   word_t       exp_data [$];
   logic [31:0] lcg_state = 32'hc8da_b57f;
   int          run_cycles = 0;

   proc uut (
      .clk     (clk),
      .rst     (rst),
      .pc      (pc),
      .instr   (instr),
      .wb_en   (wb_en),
      .wb_reg  (wb_reg),
      .wb_data (wb_data),
      .halted  (halted)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   `include "proc_model.svh"

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic end_with_failure();
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAIL %s: got %h, expected %h", name, actual, expected);
         end_with_failure();
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      check("pc", 32'(pc), 32'd0);
      check("halted", 32'(halted), 32'd0);
      instr = fetch_word(pc);
   endtask

   // Sample retirements on the falling edge, then feed the next word
   task automatic run_program();
      int writes;
      int cycles;
      writes = 0;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         // pc only steps by one until the first branch resolves
         if (cycles < SEQ_PC_CYCLES) begin
            check("pc", 32'(pc), cycles);
         end
         if (wb_en) begin
            if (writes >= exp_reg.size()) begin
               $display("Write to r%0d retired after the last write of the model", wb_reg);
               end_with_failure();
            end else begin
               check("wb_reg", 32'(wb_reg), 32'(exp_reg[writes]));
               check("wb_data", 32'(wb_data), 32'(exp_data[writes]));
               writes++;
            end
         end
         instr = fetch_word(pc);
      end while (!halted);
      check("write_count", writes, exp_reg.size());
      repeat (TAIL_CYCLES) begin
         @(negedge clk);
         if (wb_en) begin
            $display("Register r%0d was written after the processor halted", wb_reg);
            end_with_failure();
         end else begin
            check("halted", 32'(halted), 32'd1);
            instr = fetch_word(pc);
         end
      end
   endtask

   // Cycles counted only out of reset
   always @(posedge clk) begin
      if (!rst) begin
         run_cycles++;
      end
      if (run_cycles > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles without finishing all programs", run_cycles);
         end_with_failure();
      end
   end

   initial begin
      rst   = 1'b1;
      instr = HALT_WORD;
      for (int p = 0; p < NUM_PROGS; p++) begin
         build_program();
         run_model();
         apply_reset();
         run_program();
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: proc.f
+incdir+test
common/isa_pkg.sv
common/pipe_pkg.sv
decode/reg_file.sv
decode/decode.sv
execute/forward.sv
execute/execute.sv
hw/fetch.sv
hw/writeback.sv
hw/proc.sv
test/proc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := proc_tb
FILELIST  := proc.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
